// ==== logic/lsu_pkg.sv ====
// width typedefs, funct3 codes, memory constants and FSM state enums
package lsu_pkg;

    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  strobe_t;    // one bit per byte lane

    // load/store width codes
    localparam funct3_t F3_B  = 3'd0;
    localparam funct3_t F3_H  = 3'd1;
    localparam funct3_t F3_W  = 3'd2;
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

    localparam int MEM_WORDS     = 256;
    localparam int MEM_LATENCY   = 2;    // address handshake to rvalid/bvalid
    localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
    localparam int LAT_BITS      = $clog2(MEM_LATENCY + 1);

    typedef logic [MEM_ADDR_BITS-1:0] mem_idx_t;
    typedef logic [LAT_BITS-1:0]      lat_cnt_t;

    // AXI channel FSM of the load and store units
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        WAIT_RESP
    } mem_state_t;

    // data memory response FSM
    typedef enum logic [1:0] {
        S_IDLE,
        S_DELAY,
        S_RESP
    } sram_state_t;

    // stage controller
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_OUT
    } stage_state_t;

endpackage

// ==== logic/lsu_load_unit.sv ====
// lsu_load_unit module: AXI read master with lane select and funct3 extension
`timescale 1ns/10ps

module lsu_load_unit import lsu_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    load_start,
    input  word_t   req_addr,
    input  funct3_t req_funct3,
    output logic    load_done,
    output word_t   load_data,
    output logic    arvalid,
    input  logic    arready,
    output word_t   araddr,
    input  logic    rvalid,
    output logic    rready,
    input  word_t   rdata
);

    mem_state_t  state;
    logic [1:0]  byte_off;
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    word_t       ext_data;

    assign byte_off = req_addr[1:0];
    assign araddr   = {req_addr[31:2], 2'b00};    // word aligned
    assign arvalid  = (state == ADDR);
    assign rready   = (state == WAIT_RESP);

    always_comb begin
        byte_val = rdata[{byte_off, 3'b000} +: 8];
        half_val = byte_off[1] ? rdata[31:16] : rdata[15:0];
        case (req_funct3)
            F3_B: begin
                ext_data = {{24{byte_val[7]}}, byte_val};
            end
            F3_H: begin
                ext_data = {{16{half_val[15]}}, half_val};
            end
            F3_W: begin
                ext_data = rdata;
            end
            F3_BU: begin
                ext_data = {24'd0, byte_val};
            end
            F3_HU: begin
                ext_data = {16'd0, half_val};
            end
            default: begin
                ext_data = '0;    // not a load code
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (load_start) state <= ADDR;
                end
                ADDR: begin
                    if (arready) state <= WAIT_RESP;    // AR handshake
                end
                WAIT_RESP: begin
                    if (rvalid) begin
                        state     <= IDLE;
                        load_done <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // held until the next load returns
    always_ff @(posedge clock) begin
        if (state == WAIT_RESP && rvalid) load_data <= ext_data;
    end

endmodule

// ==== logic/lsu_store_unit.sv ====
// lsu_store_unit module: AXI write master with lane-aligned data and strobe
`timescale 1ns/10ps

module lsu_store_unit import lsu_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    store_start,
    input  word_t   req_addr,
    input  funct3_t req_funct3,
    input  word_t   req_store_value,
    output logic    store_done,
    output logic    awvalid,
    input  logic    awready,
    output word_t   awaddr,
    output logic    wvalid,
    input  logic    wready,
    output word_t   wdata,
    output strobe_t wstrb,
    input  logic    bvalid,
    output logic    bready
);

    mem_state_t state;
    logic       aw_pend;
    logic       w_pend;
    logic       aw_left;
    logic       w_left;
    logic [1:0] byte_off;
    strobe_t    base_strb;

    assign byte_off = req_addr[1:0];
    assign awaddr   = {req_addr[31:2], 2'b00};
    assign awvalid  = aw_pend;
    assign wvalid   = w_pend;
    assign bready   = (state == WAIT_RESP);

    // still waiting for a handshake after this cycle
    assign aw_left = aw_pend && !awready;
    assign w_left  = w_pend && !wready;

    always_comb begin
        case (req_funct3)
            F3_B:    base_strb = 4'b0001;
            F3_H:    base_strb = 4'b0011;
            default: base_strb = 4'b1111;    // sw
        endcase
    end

    assign wstrb = base_strb << byte_off;
    assign wdata = req_store_value << {byte_off, 3'b000};    // move to byte lane

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IDLE;
            aw_pend    <= 1'b0;
            w_pend     <= 1'b0;
            store_done <= 1'b0;
        end else begin
            store_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (store_start) begin
                        state   <= ADDR;
                        aw_pend <= 1'b1;    // AW and W raised together
                        w_pend  <= 1'b1;
                    end
                end
                ADDR: begin
                    aw_pend <= aw_left;
                    w_pend  <= w_left;
                    if (!aw_left && !w_left) state <= WAIT_RESP;
                end
                WAIT_RESP: begin
                    if (bvalid) begin
                        state      <= IDLE;
                        store_done <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/lsu_stage_control.sv ====
// lsu_stage_control module: pipeline register, stage handshake and result merge
`timescale 1ns/10ps

module lsu_stage_control import lsu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  word_t    pc,
    input  word_t    inst,
    input  reg_idx_t rd,
    input  logic     reg_wen,
    input  logic     mem_ren,
    input  logic     mem_wen,
    input  funct3_t  funct3,
    input  word_t    alu_result,
    input  word_t    store_value,
    output logic     out_valid,
    input  logic     out_ready,
    output word_t    pc_out,
    output word_t    inst_out,
    output reg_idx_t rd_out,
    output logic     reg_wen_out,
    output word_t    wb_data,
    output logic     load_start,
    output logic     store_start,
    output word_t    req_addr,
    output funct3_t  req_funct3,
    output word_t    req_store_value,
    input  logic     load_done,
    input  word_t    load_data,
    input  logic     store_done
);

    stage_state_t state;
    logic         accept;
    logic         unit_done;
    logic         is_load;
    word_t        alu_result_q;

    assign accept    = in_valid && in_ready;
    assign unit_done = load_done || store_done;
    assign in_ready  = (state == ST_IDLE);    // one instruction at a time

    // result is offered in the cycle the unit finishes
    assign out_valid = (state == ST_OUT) || (state == ST_BUSY && unit_done);
    assign wb_data   = is_load ? load_data : alu_result_q;
    assign req_addr  = alu_result_q;    // address for memory ops

    always_ff @(posedge clock) begin
        if (accept) begin
            pc_out          <= pc;
            inst_out        <= inst;
            rd_out          <= rd;
            reg_wen_out     <= reg_wen;
            is_load         <= mem_ren;
            req_funct3      <= funct3;
            alu_result_q    <= alu_result;
            req_store_value <= store_value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= ST_IDLE;
            load_start  <= 1'b0;
            store_start <= 1'b0;
        end else begin
            load_start  <= accept && mem_ren;
            store_start <= accept && mem_wen && !mem_ren;    // load wins if both set
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= (mem_ren || mem_wen) ? ST_BUSY : ST_OUT;
                    end
                end
                ST_BUSY: begin
                    if (unit_done) begin
                        state <= out_ready ? ST_IDLE : ST_OUT;
                    end
                end
                ST_OUT: begin
                    if (out_ready) state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/data_sram_axi.sv ====
// data_sram_axi module: AXI slave word memory, byte strobes, fixed response delay
`timescale 1ns/10ps

module data_sram_axi import lsu_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    arvalid,
    output logic    arready,
    input  word_t   araddr,
    output logic    rvalid,
    input  logic    rready,
    output word_t   rdata,
    input  logic    awvalid,
    output logic    awready,
    input  word_t   awaddr,
    input  logic    wvalid,
    output logic    wready,
    input  word_t   wdata,
    input  strobe_t wstrb,
    output logic    bvalid,
    input  logic    bready
);

    word_t       mem [MEM_WORDS];
    sram_state_t state;
    lat_cnt_t    delay_cnt;
    logic        is_write;
    logic        aw_seen;
    logic        w_seen;
    word_t       aw_addr_q;
    word_t       w_data_q;
    strobe_t     w_strb_q;
    logic        ar_fire;
    logic        aw_fire;
    logic        w_fire;
    logic        wr_go;
    word_t       wr_addr;
    word_t       wr_data;
    strobe_t     wr_strb;
    mem_idx_t    wr_idx;
    mem_idx_t    rd_idx;

    assign arready = (state == S_IDLE) && !aw_seen && !w_seen;
    assign awready = (state == S_IDLE) && !aw_seen && !arvalid;    // reads first
    assign wready  = (state == S_IDLE) && !w_seen && !arvalid;

    assign ar_fire = arvalid && arready;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // write goes once both address and data are in
    assign wr_go   = (aw_seen || aw_fire) && (w_seen || w_fire);
    assign wr_addr = aw_seen ? aw_addr_q : awaddr;
    assign wr_data = w_seen ? w_data_q : wdata;
    assign wr_strb = w_seen ? w_strb_q : wstrb;
    assign wr_idx  = wr_addr[MEM_ADDR_BITS+1:2];
    assign rd_idx  = araddr[MEM_ADDR_BITS+1:2];

    assign rvalid = (state == S_RESP) && !is_write;
    assign bvalid = (state == S_RESP) && is_write;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= S_IDLE;
            delay_cnt <= '0;
            is_write  <= 1'b0;
            aw_seen   <= 1'b0;
            w_seen    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ar_fire) begin
                        state     <= S_DELAY;
                        is_write  <= 1'b0;
                        delay_cnt <= lat_cnt_t'(MEM_LATENCY - 1);
                    end else if (wr_go) begin
                        state     <= S_DELAY;
                        is_write  <= 1'b1;
                        delay_cnt <= lat_cnt_t'(MEM_LATENCY - 1);
                        aw_seen   <= 1'b0;
                        w_seen    <= 1'b0;
                    end else begin
                        if (aw_fire) aw_seen <= 1'b1;
                        if (w_fire) w_seen <= 1'b1;
                    end
                end
                S_DELAY: begin
                    delay_cnt <= delay_cnt - 1'b1;
                    if (delay_cnt == lat_cnt_t'(1)) state <= S_RESP;
                end
                S_RESP: begin
                    if ((rvalid && rready) || (bvalid && bready)) state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) mem[i] <= '0;
        end else if (wr_go) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[b]) mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire) aw_addr_q <= awaddr;
        if (w_fire) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (ar_fire) rdata <= mem[rd_idx];    // held through S_RESP
    end

endmodule

// ==== logic/mem_stage_top.sv ====
// mem_stage_top module: stage control, load and store units and data memory
`timescale 1ns/10ps

module mem_stage_top import lsu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  word_t    pc,
    input  word_t    inst,
    input  reg_idx_t rd,
    input  logic     reg_wen,
    input  logic     mem_ren,
    input  logic     mem_wen,
    input  funct3_t  funct3,
    input  word_t    alu_result,
    input  word_t    store_value,
    output logic     out_valid,
    input  logic     out_ready,
    output word_t    pc_out,
    output word_t    inst_out,
    output reg_idx_t rd_out,
    output logic     reg_wen_out,
    output word_t    wb_data
);

    logic    load_start;
    logic    store_start;
    word_t   req_addr;
    funct3_t req_funct3;
    word_t   req_store_value;
    logic    load_done;
    word_t   load_data;
    logic    store_done;

    // AXI between the units and the memory
    logic    arvalid;
    logic    arready;
    word_t   araddr;
    logic    rvalid;
    logic    rready;
    word_t   rdata;
    logic    awvalid;
    logic    awready;
    word_t   awaddr;
    logic    wvalid;
    logic    wready;
    word_t   wdata;
    strobe_t wstrb;
    logic    bvalid;
    logic    bready;

    lsu_stage_control u_control (
        .clock, .reset,
        .in_valid, .in_ready, .pc, .inst, .rd, .reg_wen,
        .mem_ren, .mem_wen, .funct3, .alu_result, .store_value,
        .out_valid, .out_ready, .pc_out, .inst_out, .rd_out, .reg_wen_out, .wb_data,
        .load_start, .store_start, .req_addr, .req_funct3, .req_store_value,
        .load_done, .load_data, .store_done
    );

    lsu_load_unit u_load (
        .clock, .reset,
        .load_start, .req_addr, .req_funct3, .load_done, .load_data,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata
    );

    lsu_store_unit u_store (
        .clock, .reset,
        .store_start, .req_addr, .req_funct3, .req_store_value, .store_done,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready
    );

    data_sram_axi u_sram (
        .clock, .reset,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready
    );

endmodule

// ==== tests/mem_stage_tb.sv ====
// mem_stage_tb module: trace-driven checks of the memory stage under random write-back stalls
`timescale 1ns/10ps

module mem_stage_tb import lsu_pkg::*; ();

    localparam int    WAIT_LIMIT = 200;    // cycles per wait
    localparam word_t PC_BASE    = 32'h0000_1000;

    logic     clock;
    logic     reset;
    logic     in_valid;
    logic     in_ready;
    word_t    pc;
    word_t    inst;
    reg_idx_t rd;
    logic     reg_wen;
    logic     mem_ren;
    logic     mem_wen;
    funct3_t  funct3;
    word_t    alu_result;
    word_t    store_value;
    logic     out_valid;
    logic     out_ready;
    word_t    pc_out;
    word_t    inst_out;
    reg_idx_t rd_out;
    logic     reg_wen_out;
    word_t    wb_data;

    // results still owed by the DUT in issue order
    word_t    exp_pc[$];
    word_t    exp_inst[$];
    reg_idx_t exp_rd[$];
    logic     exp_wen[$];
    word_t    exp_wb[$];

    int          error_count;
    int          timeout_count;
    int          issued_count;
    int          result_count;
    int          in_flight;
    logic        held;    // result offered but stalled last cycle
    logic [31:0] rng_state;

    mem_stage_top dut0 (
        .clock, .reset,
        .in_valid, .in_ready, .pc, .inst, .rd, .reg_wen,
        .mem_ren, .mem_wen, .funct3, .alu_result, .store_value,
        .out_valid, .out_ready, .pc_out, .inst_out, .rd_out, .reg_wen_out, .wb_data
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // drive one instruction and hold it until the stage takes it
    task automatic send_instr(input logic ld, input logic st, input funct3_t f3,
                              input word_t addr, input word_t sval, input reg_idx_t rd_v,
                              input word_t exp_v, input int n);
        int         waited;
        logic [6:0] opc;
        opc         = ld ? 7'h03 : (st ? 7'h23 : 7'h13);
        pc          = PC_BASE + 4 * n;
        inst        = {n[16:0], f3, rd_v, opc};
        rd          = rd_v;
        reg_wen     = !st;
        mem_ren     = ld;
        mem_wen     = st;
        funct3      = f3;
        alu_result  = addr;
        store_value = sval;
        in_valid    = 1'b1;
        waited      = 0;
        @(negedge clock);
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (in_ready) begin
            exp_pc.push_back(pc);
            exp_inst.push_back(inst);
            exp_rd.push_back(rd_v);
            exp_wen.push_back(!st);
            exp_wb.push_back(exp_v);
        end else begin
            $display("timed out waiting for in_ready on trace entry %0d", n);
            timeout_count++;
        end
        @(posedge clock);
        #2;
        in_valid = 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // random write-back stalls
    initial begin
        rng_state = 32'h1960;
        out_ready = 1'b0;
        forever begin
            @(posedge clock);
            #2;
            rng_state = xorshift32(rng_state);
            out_ready = (rng_state[2:0] > 3'd2);
        end
    end

    always @(negedge clock) begin
        if (!reset) begin
            if (in_flight > 0 && in_ready) begin
                $display("[ERROR] in_ready = %h while busy, expected 0", in_ready);
                error_count++;
            end
            if (held && !out_valid) begin
                $display("[ERROR] out_valid = %h during a stall, expected 1", out_valid);
                error_count++;
            end
            if (in_valid && in_ready) in_flight++;
            if (out_valid) begin
                if (exp_wb.size() == 0) begin
                    $display("[ERROR] out_valid = %h with nothing outstanding, expected 0",
                             out_valid);
                    error_count++;
                end else begin
                    if (pc_out !== exp_pc[0]) begin
                        $display("[ERROR] pc_out = %h, expected %h", pc_out, exp_pc[0]);
                        error_count++;
                    end
                    if (inst_out !== exp_inst[0]) begin
                        $display("[ERROR] inst_out = %h, expected %h", inst_out, exp_inst[0]);
                        error_count++;
                    end
                    if (rd_out !== exp_rd[0]) begin
                        $display("[ERROR] rd_out = %h, expected %h", rd_out, exp_rd[0]);
                        error_count++;
                    end
                    if (reg_wen_out !== exp_wen[0]) begin
                        $display("[ERROR] reg_wen_out = %h, expected %h", reg_wen_out, exp_wen[0]);
                        error_count++;
                    end
                    if (wb_data !== exp_wb[0]) begin
                        $display("[ERROR] wb_data = %h, expected %h", wb_data, exp_wb[0]);
                        error_count++;
                    end
                    if (out_ready) begin    // transfer at the next edge
                        void'(exp_pc.pop_front());
                        void'(exp_inst.pop_front());
                        void'(exp_rd.pop_front());
                        void'(exp_wen.pop_front());
                        void'(exp_wb.pop_front());
                        result_count++;
                        in_flight--;
                    end
                end
            end
            held = out_valid && !out_ready;
        end
    end

    initial begin
        int                fd;
        int                code;
        int                waited;
        logic              done;
        logic              is_ld;
        logic              is_st;
        logic [63:0]       kind_txt;
        logic [8*200-1:0]  skip_buf;
        funct3_t           f3;
        word_t             addr;
        word_t             sval;
        reg_idx_t          rd_v;
        word_t             exp_v;
        error_count   = 0;
        timeout_count = 0;
        issued_count  = 0;
        result_count  = 0;
        in_flight     = 0;
        held          = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        pc            = '0;
        inst          = '0;
        rd            = '0;
        reg_wen       = 1'b0;
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        funct3        = '0;
        alu_result    = '0;
        store_value   = '0;
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        @(negedge clock);
        if (out_valid !== 1'b0) begin
            $display("[ERROR] out_valid = %h after reset, expected 0", out_valid);
            error_count++;
        end
        if (in_ready !== 1'b1) begin
            $display("[ERROR] in_ready = %h after reset, expected 1", in_ready);
            error_count++;
        end
        @(posedge clock);
        #2;
        fd = $fopen("tests/mem_stage_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tests/mem_stage_trace.txt");
            error_count++;
        end else begin
            done = 1'b0;
            while (!done && timeout_count == 0) begin
                code = $fscanf(fd, "%s", kind_txt);
                if (code != 1) begin
                    done = 1'b1;
                end else if (kind_txt == 64'("#")) begin
                    code = $fgets(skip_buf, fd);    // rest of a comment line
                end else begin
                    code  = $fscanf(fd, "%h %h %h %d %h", f3, addr, sval, rd_v, exp_v);
                    is_ld = (kind_txt == 64'("load"));
                    is_st = (kind_txt == 64'("store"));
                    if (code != 5 || !(is_ld || is_st || kind_txt == 64'("alu"))) begin
                        $display("malformed trace entry after %0d instructions", issued_count);
                        error_count++;
                        done = 1'b1;
                    end else begin
                        send_instr(is_ld, is_st, f3, addr, sval, rd_v, exp_v, issued_count);
                        issued_count++;
                    end
                end
            end
            $fclose(fd);
        end
        waited = 0;
        while (in_flight > 0 && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (in_flight > 0) begin
            $display("timed out waiting for the last result on out_valid");
            timeout_count++;
        end
        if (result_count != issued_count) begin
            $display("%0d instructions issued but %0d results seen", issued_count, result_count);
            error_count++;
        end
        $display("errors: %0d, timeouts: %0d, results: %0d of %0d",
                 error_count, timeout_count, result_count, issued_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/mem_stage_trace.txt ====
# kind funct3 alu_result(address) store_value rd expected_wb_data
# all hex except rd (decimal); a store expects its address back on wb_data
alu   0 12345678 00000000  1 12345678
load  2 00000300 00000000  2 00000000
store 2 00000100 deadbeef  0 00000100
load  2 00000100 00000000  4 deadbeef
alu   0 cafef00d 00000000  3 cafef00d
store 0 00000200 000000a1  0 00000200
store 0 00000201 ffffffb2  0 00000201
store 0 00000202 123456c3  0 00000202
store 0 00000203 000000d4  0 00000203
load  2 00000200 00000000  5 d4c3b2a1
load  0 00000200 00000000  6 ffffffa1
load  4 00000200 00000000  7 000000a1
load  0 00000201 00000000  8 ffffffb2
load  4 00000202 00000000  9 000000c3
load  0 00000203 00000000 10 ffffffd4
load  4 00000203 00000000 11 000000d4
load  1 00000200 00000000 12 ffffb2a1
load  5 00000200 00000000 13 0000b2a1
load  1 00000202 00000000 14 ffffd4c3
load  5 00000202 00000000 15 0000d4c3
store 1 00000100 00001234  0 00000100
store 1 00000102 ffff5678  0 00000102
load  2 00000100 00000000 16 56781234
store 0 00000101 0000007f  0 00000101
load  2 00000100 00000000 17 56787f34
load  0 00000101 00000000 18 0000007f
load  1 00000100 00000000 19 00007f34
store 2 000003fc 80000001  0 000003fc
load  2 000003fc 00000000 20 80000001
load  1 000003fe 00000000 21 ffff8000
load  5 000003fe 00000000 22 00008000
load  0 000003fc 00000000 23 00000001
alu   0 ffffffff 00000000 31 ffffffff
load  2 00000204 00000000 24 00000000
store 1 00000204 abcd8765  0 00000204
load  2 00000204 00000000 25 00008765
alu   0 00000000 00000000  0 00000000
load  4 00000205 00000000 26 00000087

// ==== compile.f ====
logic/lsu_pkg.sv
logic/lsu_load_unit.sv
logic/lsu_store_unit.sv
logic/lsu_stage_control.sv
logic/data_sram_axi.sv
logic/mem_stage_top.sv
tests/mem_stage_tb.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := mem_stage_tb
FILELIST := compile.f
OBJDIR   := obj_dir
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
